// ==== kh_params.svh ====
`ifndef KH_PARAMS_SVH
`define KH_PARAMS_SVH

// register file geometry
`define KH_WORD_W             32
`define KH_ARG_NUM            8
`define KH_IDX_W              3
`define KH_IDX_LO             2

// register map
`define KH_IDX_CMD            0
`define KH_IDX_HB_RESET       5
`define KH_IDX_HB_START       6
`define KH_CMD_RESET_VAL      32'hDEADBEEF

// watchdog timing in clk cycles
`define KH_WDOG_TIMEOUT       64
`define KH_WDOG_RESET_CYCLES  16

`endif

// ==== kh_pkg.sv ====
`include "kh_params.svh"

package kh_pkg;

  // master side of the AXI-lite slave port
  typedef struct packed {
    logic [`KH_WORD_W-1:0]   araddr;
    logic                    arvalid;
    logic [`KH_WORD_W-1:0]   awaddr;
    logic                    awvalid;
    logic [`KH_WORD_W-1:0]   wdata;
    logic [`KH_WORD_W/8-1:0] wstrb;
    logic                    wvalid;
    logic                    bready;
    logic                    rready;
  } axil_req_t;

  // slave side
  typedef struct packed {
    logic                  arready;
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  rvalid;
    logic [`KH_WORD_W-1:0] rdata;
    logic [1:0]            rresp;
  } axil_rsp_t;

  // status words reported by the core
  typedef struct packed {
    logic [`KH_WORD_W-1:0] state0;
    logic [`KH_WORD_W-1:0] state1;
    logic [`KH_WORD_W-1:0] state2;
    logic [`KH_WORD_W-1:0] state3;
  } core_state_t;

  // one command beat towards the core
  typedef struct packed {
    logic                  valid;
    logic [`KH_WORD_W-1:0] command;
    logic [`KH_WORD_W-1:0] data0;
    logic [`KH_WORD_W-1:0] data1;
  } cmd_port_t;

  typedef logic [`KH_ARG_NUM-1:0][`KH_WORD_W-1:0] arg_array_t;

endpackage

// ==== axil_ctrl.sv ====
`include "kh_params.svh"

module axil_ctrl (
  input  logic                  clk,
  input  logic                  rstn,
  input  kh_pkg::axil_req_t     axil_req_i,
  input  logic [`KH_WORD_W-1:0] rd_data_i,
  output kh_pkg::axil_rsp_t     axil_rsp_o,
  output logic [`KH_IDX_W-1:0]  rd_idx_o,
  output logic                  wr_en_o,
  output logic [`KH_IDX_W-1:0]  wr_idx_o,
  output logic [`KH_WORD_W-1:0] wr_data_o
);

  logic                  arready_q;
  logic                  rvalid_q;
  logic [`KH_WORD_W-1:0] rdata_q;
  logic                  awready_q;
  logic                  wready_q;
  logic                  aw_rcvd_q;
  logic                  w_rcvd_q;
  logic                  bvalid_q;
  logic [`KH_IDX_W-1:0]  wr_idx_q;
  logic [`KH_WORD_W-1:0] wr_data_q;

  logic ar_hs;
  logic r_hs;
  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic wr_commit;

  assign ar_hs     = axil_req_i.arvalid & arready_q;
  assign r_hs      = axil_req_i.rready & rvalid_q;
  assign aw_hs     = axil_req_i.awvalid & awready_q;
  assign w_hs      = axil_req_i.wvalid & wready_q;
  assign b_hs      = axil_req_i.bready & bvalid_q;
  // address and data both in hand
  assign wr_commit = aw_rcvd_q & w_rcvd_q;

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  assign rd_idx_o = axil_req_i.araddr[`KH_IDX_LO +: `KH_IDX_W];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      arready_q <= 1'b1;
      rvalid_q  <= 1'b0;
    end else if (ar_hs) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b1;
    end else if (r_hs) begin
      arready_q <= 1'b1;
      rvalid_q  <= 1'b0;
    end
  end

  // sampled at AR handshake and held until rready
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata_q <= rd_data_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      awready_q <= 1'b1;
      wready_q  <= 1'b1;
      aw_rcvd_q <= 1'b0;
      w_rcvd_q  <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      if (aw_hs) begin
        awready_q <= 1'b0;
        aw_rcvd_q <= 1'b1;
      end
      if (w_hs) begin
        wready_q <= 1'b0;
        w_rcvd_q <= 1'b1;
      end
      if (wr_commit) begin
        aw_rcvd_q <= 1'b0;
        w_rcvd_q  <= 1'b0;
        bvalid_q  <= 1'b1;
      end
      // reopen both channels once the response is taken
      if (b_hs) begin
        bvalid_q  <= 1'b0;
        awready_q <= 1'b1;
        wready_q  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_idx_q <= axil_req_i.awaddr[`KH_IDX_LO +: `KH_IDX_W];
    end
    if (w_hs) begin
      wr_data_q <= axil_req_i.wdata;
    end
  end

  assign wr_en_o   = wr_commit;
  assign wr_idx_o  = wr_idx_q;
  assign wr_data_o = wr_data_q;

  always_comb begin
    axil_rsp_o.arready = arready_q;
    axil_rsp_o.awready = awready_q;
    axil_rsp_o.wready  = wready_q;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = 2'b00;
    axil_rsp_o.rvalid  = rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = 2'b00;
  end

endmodule

// ==== kernel_reg_bank.sv ====
`include "kh_params.svh"

module kernel_reg_bank (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  wr_en_i,
  input  logic [`KH_IDX_W-1:0]  wr_idx_i,
  input  logic [`KH_WORD_W-1:0] wr_data_i,
  input  logic [`KH_IDX_W-1:0]  rd_idx_i,
  input  kh_pkg::core_state_t   core_state_i,
  output logic [`KH_WORD_W-1:0] rd_data_o,
  output kh_pkg::arg_array_t    args_o,
  output logic                  cmd_new_o,
  output logic                  hb_start_o,
  output logic                  hb_kick_o
);

  import kh_pkg::*;

  arg_array_t args_q;
  logic       cmd_new_q;
  logic       hb_start_q;
  logic       hb_kick_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      args_q              <= '0;
      args_q[`KH_IDX_CMD] <= `KH_CMD_RESET_VAL;
      hb_start_q          <= 1'b0;
      hb_kick_q           <= 1'b0;
      cmd_new_q           <= 1'b0;
    end else begin
      // launch strobe lines up with bvalid
      cmd_new_q <= wr_en_i && (wr_idx_i == `KH_IDX_W'(`KH_IDX_CMD));
      if (wr_en_i) begin
        case (wr_idx_i)
          `KH_IDX_W'(`KH_IDX_HB_RESET): hb_kick_q  <= wr_data_i[0];
          `KH_IDX_W'(`KH_IDX_HB_START): hb_start_q <= wr_data_i[0];
          default:                      args_q[wr_idx_i] <= wr_data_i;
        endcase
      end
    end
  end

  // read map mixes stored args and live core status
  always_comb begin
    case (rd_idx_i)
      `KH_IDX_W'(`KH_IDX_CMD): rd_data_o = args_q[`KH_IDX_CMD];
      `KH_IDX_W'(1):           rd_data_o = core_state_i.state0;
      `KH_IDX_W'(2):           rd_data_o = core_state_i.state1;
      `KH_IDX_W'(3):           rd_data_o = core_state_i.state2;
      `KH_IDX_W'(4):           rd_data_o = core_state_i.state3;
      default:                 rd_data_o = '0;
    endcase
  end

  assign args_o     = args_q;
  assign cmd_new_o  = cmd_new_q;
  assign hb_start_o = hb_start_q;
  assign hb_kick_o  = hb_kick_q;

endmodule

// ==== cmd_launcher.sv ====
`include "kh_params.svh"

module cmd_launcher (
  input  logic               clk,
  input  logic               rstn,
  input  logic               cmd_new_i,
  input  kh_pkg::arg_array_t args_i,
  output kh_pkg::cmd_port_t  cmd_o
);

  // argument slots feeding the command beat
  localparam int ARG_COMMAND = 1;
  localparam int ARG_DATA0   = 2;
  localparam int ARG_DATA1   = 3;
  localparam int ARG_DELAY   = 4;

  logic                  busy_q;
  logic [`KH_WORD_W-1:0] delay_q;

  // a fresh launch restarts the countdown
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_q  <= 1'b0;
      delay_q <= '0;
    end else if (cmd_new_i) begin
      busy_q  <= 1'b1;
      delay_q <= args_i[ARG_DELAY];
    end else if (busy_q) begin
      if (delay_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        delay_q <= delay_q - 1'b1;
      end
    end
  end

  always_comb begin
    cmd_o.valid   = busy_q && (delay_q == '0);
    cmd_o.command = args_i[ARG_COMMAND];
    cmd_o.data0   = args_i[ARG_DATA0];
    cmd_o.data1   = args_i[ARG_DATA1];
  end

endmodule

// ==== heartbeat_watchdog.sv ====
`include "kh_params.svh"

module heartbeat_watchdog (
  input  logic clk,
  input  logic rstn,
  input  logic hb_start_i,
  input  logic hb_kick_i,
  output logic wdog_reset_o
);

  localparam int CNT_W = $clog2(`KH_WDOG_TIMEOUT + 1);
  localparam int RST_W = $clog2(`KH_WDOG_RESET_CYCLES + 1);

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`KH_WDOG_TIMEOUT - 1);
  localparam logic [RST_W-1:0] RST_LAST = RST_W'(`KH_WDOG_RESET_CYCLES - 1);

  typedef enum logic [1:0] {
    ST_IDLE      = 2'b00,
    ST_WAIT      = 2'b01,
    ST_HEARTBEAT = 2'b10,
    ST_REVIVE    = 2'b11
  } wdog_state_e;

  wdog_state_e      state_q;
  wdog_state_e      state_d;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic [RST_W-1:0] rst_cnt_q;
  logic [RST_W-1:0] rst_cnt_d;

  //////////////////////////////////////////////////////////////////////
  // next state and counters
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q;
    rst_cnt_d = rst_cnt_q;
    if (!hb_start_i) begin
      state_d   = ST_IDLE;
      cnt_d     = '0;
      rst_cnt_d = '0;
    end else begin
      case (state_q)
        ST_IDLE, ST_HEARTBEAT: begin
          cnt_d   = '0;
          state_d = hb_kick_i ? ST_HEARTBEAT : ST_WAIT;
        end
        ST_WAIT: begin
          if (hb_kick_i) begin
            state_d = ST_HEARTBEAT;
            cnt_d   = '0;
          end else if (cnt_q == CNT_LAST) begin
            // pulse length loaded on entry to revive
            state_d   = ST_REVIVE;
            cnt_d     = '0;
            rst_cnt_d = RST_LAST;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
        ST_REVIVE: begin
          if (rst_cnt_q == '0) begin
            state_d = ST_WAIT;
            cnt_d   = '0;
          end else begin
            rst_cnt_d = rst_cnt_q - 1'b1;
          end
        end
        default: begin
          state_d = ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q   <= ST_IDLE;
      cnt_q     <= '0;
      rst_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      cnt_q     <= cnt_d;
      rst_cnt_q <= rst_cnt_d;
    end
  end

  assign wdog_reset_o = (state_q == ST_REVIVE);

endmodule

// ==== kernel_host_top.sv ====
`include "kh_params.svh"

module kernel_host_top (
  input  logic                clk,
  input  logic                rstn,
  input  kh_pkg::axil_req_t   axil_req_i,
  output kh_pkg::axil_rsp_t   axil_rsp_o,
  input  kh_pkg::core_state_t core_state_i,
  output kh_pkg::cmd_port_t   cmd_o,
  input  logic                switch_button_i,
  output logic                core_reset_o
);

  import kh_pkg::*;

  logic [`KH_IDX_W-1:0]  rd_idx;
  logic [`KH_WORD_W-1:0] rd_data;
  logic                  wr_en;
  logic [`KH_IDX_W-1:0]  wr_idx;
  logic [`KH_WORD_W-1:0] wr_data;
  arg_array_t            args;
  logic                  cmd_new;
  logic                  hb_start;
  logic                  hb_kick;
  logic                  wdog_reset;
  logic                  core_reset_q;

  axil_ctrl u_axil_ctrl (
    .clk        (clk),
    .rstn       (rstn),
    .axil_req_i (axil_req_i),
    .rd_data_i  (rd_data),
    .axil_rsp_o (axil_rsp_o),
    .rd_idx_o   (rd_idx),
    .wr_en_o    (wr_en),
    .wr_idx_o   (wr_idx),
    .wr_data_o  (wr_data)
  );

  kernel_reg_bank u_kernel_reg_bank (
    .clk          (clk),
    .rstn         (rstn),
    .wr_en_i      (wr_en),
    .wr_idx_i     (wr_idx),
    .wr_data_i    (wr_data),
    .rd_idx_i     (rd_idx),
    .core_state_i (core_state_i),
    .rd_data_o    (rd_data),
    .args_o       (args),
    .cmd_new_o    (cmd_new),
    .hb_start_o   (hb_start),
    .hb_kick_o    (hb_kick)
  );

  cmd_launcher u_cmd_launcher (
    .clk       (clk),
    .rstn      (rstn),
    .cmd_new_i (cmd_new),
    .args_i    (args),
    .cmd_o     (cmd_o)
  );

  heartbeat_watchdog u_heartbeat_watchdog (
    .clk          (clk),
    .rstn         (rstn),
    .hb_start_i   (hb_start),
    .hb_kick_i    (hb_kick),
    .wdog_reset_o (wdog_reset)
  );

  // watchdog or button merged one cycle late
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      core_reset_q <= 1'b0;
    end else begin
      core_reset_q <= wdog_reset | switch_button_i;
    end
  end

  assign core_reset_o = core_reset_q;

endmodule

// ==== tb_kernel_host.sv ====
`include "kh_params.svh"

module tb_kernel_host;

  import kh_pkg::*;

  localparam int TIMEOUT   = 200;
  localparam int BP_CYCLES = 5;

  localparam logic [2:0] OP_RD     = 3'd0;
  localparam logic [2:0] OP_WR     = 3'd1;
  localparam logic [2:0] OP_LAUNCH = 3'd2;
  localparam logic [2:0] OP_RD_BP  = 3'd3;
  localparam logic [2:0] OP_WR_BP  = 3'd4;
  localparam logic [2:0] OP_WDOG   = 3'd5;
  localparam logic [2:0] OP_BUTTON = 3'd6;

  localparam int SEL_AR   = 0;
  localparam int SEL_AW   = 1;
  localparam int SEL_W    = 2;
  localparam int SEL_B    = 3;
  localparam int SEL_R    = 4;
  localparam int SEL_CRST = 5;

  typedef struct packed {
    logic [2:0]  op;
    logic [2:0]  idx;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic [31:0] delay;
  } entry_t;

  logic        clk;
  logic        rstn;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  core_state_t core_state;
  cmd_port_t   cmd;
  logic        switch_button;
  logic        core_reset;

  entry_t      tbl[$];
  integer      seed;
  int          errors;
  int          timeouts;
  int          cyc;
  int          b_cyc;
  int          cmd_pulses;
  int          cmd_cyc;
  cmd_port_t   cmd_seen;
  logic [31:0] rd_word;

  kernel_host_top u_kernel_host_top (
    .clk             (clk),
    .rstn            (rstn),
    .axil_req_i      (axil_req),
    .axil_rsp_o      (axil_rsp),
    .core_state_i    (core_state),
    .cmd_o           (cmd),
    .switch_button_i (switch_button),
    .core_reset_o    (core_reset)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // every command beat seen by the core
  always @(negedge clk) begin
    if (rstn && cmd.valid) begin
      cmd_pulses = cmd_pulses + 1;
      cmd_cyc    = cyc;
      cmd_seen   = cmd;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("Fail %0t: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  function automatic logic sample_flag(input int sel);
    case (sel)
      SEL_AR:  return axil_rsp.arready;
      SEL_AW:  return axil_rsp.awready;
      SEL_W:   return axil_rsp.wready;
      SEL_B:   return axil_rsp.bvalid;
      SEL_R:   return axil_rsp.rvalid;
      default: return core_reset;
    endcase
  endfunction

  // polls one response flag per falling edge
  task automatic wait_high(input int sel, input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!sample_flag(sel) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!sample_flag(sel)) begin
      $display("timeout while waiting for %s", what);
      timeouts++;
    end
  endtask

  task automatic send_aw(input logic [2:0] idx);
    @(posedge clk);
    axil_req.awaddr  <= 32'(idx) << `KH_IDX_LO;
    axil_req.awvalid <= 1'b1;
    wait_high(SEL_AW, TIMEOUT, "awready");
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
  endtask

  task automatic send_w(input logic [31:0] data);
    @(posedge clk);
    axil_req.wdata  <= data;
    axil_req.wstrb  <= '1;
    axil_req.wvalid <= 1'b1;
    wait_high(SEL_W, TIMEOUT, "wready");
    @(posedge clk);
    axil_req.wvalid <= 1'b0;
  endtask

  task automatic write_reg(input logic [2:0] idx, input logic [31:0] data,
                           input logic w_first, input int bp);
    if (w_first) begin
      send_w(data);
      send_aw(idx);
    end else begin
      send_aw(idx);
      send_w(data);
    end
    wait_high(SEL_B, TIMEOUT, "bvalid");
    b_cyc = cyc;
    check(axil_rsp.bresp, 2'b00, "bresp");
    repeat (bp) begin
      @(negedge clk);
      check(axil_rsp.bvalid, 1'b1, "bvalid under back-pressure");
      check(axil_rsp.awready, 1'b0, "awready under back-pressure");
      check(axil_rsp.wready, 1'b0, "wready under back-pressure");
    end
    @(posedge clk);
    axil_req.bready <= 1'b1;
    @(posedge clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] idx, input int bp, output logic [31:0] data);
    @(posedge clk);
    axil_req.araddr  <= 32'(idx) << `KH_IDX_LO;
    axil_req.arvalid <= 1'b1;
    wait_high(SEL_AR, TIMEOUT, "arready");
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    wait_high(SEL_R, TIMEOUT, "rvalid");
    data = axil_rsp.rdata;
    check(axil_rsp.rresp, 2'b00, "rresp");
    repeat (bp) begin
      @(negedge clk);
      check(axil_rsp.rvalid, 1'b1, "rvalid under back-pressure");
      check(axil_rsp.rdata, data, "rdata under back-pressure");
      check(axil_rsp.arready, 1'b0, "arready under back-pressure");
    end
    @(posedge clk);
    axil_req.rready <= 1'b1;
    @(posedge clk);
    axil_req.rready <= 1'b0;
  endtask

  task automatic launch_and_check(input logic [31:0] delay, input logic [31:0] wdata);
    logic [31:0] command;
    logic [31:0] data0;
    logic [31:0] data1;
    int          n;
    command = $random(seed);
    data0   = $random(seed);
    data1   = $random(seed);
    write_reg(3'd4, delay, 1'b0, 0);
    write_reg(3'd1, command, 1'b0, 0);
    write_reg(3'd2, data0, 1'b0, 0);
    write_reg(3'd3, data1, 1'b0, 0);
    cmd_pulses = 0;
    write_reg(3'(`KH_IDX_CMD), wdata, 1'b0, 0);
    n = 0;
    while (cmd_pulses == 0 && n < delay + TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (cmd_pulses == 0) begin
      $display("timeout while waiting for the command beat, delay %0d", delay);
      timeouts++;
    end else begin
      // make sure no second beat follows
      repeat (4) @(negedge clk);
      check(cmd_pulses, 1, "command beat count");
      check(cmd_cyc - b_cyc, delay + 1, "command delay after bvalid");
      check(cmd_seen.command, command, "command word");
      check(cmd_seen.data0, data0, "data0 word");
      check(cmd_seen.data1, data1, "data1 word");
    end
  endtask

  task automatic watchdog_reset_test();
    int n;
    write_reg(3'(`KH_IDX_HB_RESET), 32'd0, 1'b0, 0);
    write_reg(3'(`KH_IDX_HB_START), 32'd1, 1'b0, 0);
    wait_high(SEL_CRST, 4 * `KH_WDOG_TIMEOUT, "watchdog core reset");
    n = 0;
    while (core_reset && n < 4 * `KH_WDOG_RESET_CYCLES) begin
      @(negedge clk);
      n++;
    end
    check(n, `KH_WDOG_RESET_CYCLES, "watchdog reset length");
    write_reg(3'(`KH_IDX_HB_RESET), 32'd1, 1'b0, 0);
    n = 0;
    repeat (3 * `KH_WDOG_TIMEOUT) begin
      @(negedge clk);
      if (core_reset) begin
        n++;
      end
    end
    check(n, 0, "core reset cycles while kicked");
    write_reg(3'(`KH_IDX_HB_START), 32'd0, 1'b0, 0);
    write_reg(3'(`KH_IDX_HB_RESET), 32'd0, 1'b0, 0);
  endtask

  // merge register adds one cycle of lag
  task automatic pulse_button();
    @(posedge clk);
    switch_button <= 1'b1;
    @(negedge clk);
    check(core_reset, 1'b0, "core reset before button edge");
    @(posedge clk);
    switch_button <= 1'b0;
    @(negedge clk);
    check(core_reset, 1'b1, "core reset after button");
    @(negedge clk);
    check(core_reset, 1'b0, "core reset one cycle wide");
  endtask

  task automatic add_entry(input logic [2:0] op, input logic [2:0] idx,
                           input logic [31:0] wdata, input logic [31:0] exp,
                           input logic [31:0] delay);
    entry_t e;
    e.op    = op;
    e.idx   = idx;
    e.wdata = wdata;
    e.exp   = exp;
    e.delay = delay;
    tbl.push_back(e);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    seed          = 32'h22a215e4;
    errors        = 0;
    timeouts      = 0;
    cyc           = 0;
    b_cyc         = 0;
    cmd_pulses    = 0;
    clk           = 1'b0;
    rstn          = 1'b0;
    axil_req      = '0;
    switch_button = 1'b0;
    core_state.state0 = $random(seed);
    core_state.state1 = $random(seed);
    core_state.state2 = $random(seed);
    core_state.state3 = $random(seed);

    // reset values and register map
    add_entry(OP_RD, 3'd0, 32'd0, 32'hDEADBEEF, 32'd0);
    add_entry(OP_RD, 3'd7, 32'd0, 32'd0, 32'd0);
    r = $random(seed);
    add_entry(OP_WR, 3'd0, r, 32'd0, 32'd0);
    add_entry(OP_RD, 3'd0, 32'd0, r, 32'd0);
    add_entry(OP_RD, 3'd1, 32'd0, core_state.state0, 32'd0);
    add_entry(OP_RD, 3'd2, 32'd0, core_state.state1, 32'd0);
    add_entry(OP_RD, 3'd3, 32'd0, core_state.state2, 32'd0);
    add_entry(OP_RD, 3'd4, 32'd0, core_state.state3, 32'd0);
    add_entry(OP_WR, 3'd6, $random(seed), 32'd0, 32'd0);
    add_entry(OP_RD, 3'd6, 32'd0, 32'd0, 32'd0);
    add_entry(OP_WR, 3'd6, 32'd0, 32'd0, 32'd0);
    add_entry(OP_WR, 3'd5, $random(seed), 32'd0, 32'd0);
    add_entry(OP_RD, 3'd5, 32'd0, 32'd0, 32'd0);
    add_entry(OP_WR, 3'd5, 32'd0, 32'd0, 32'd0);
    // command launch
    add_entry(OP_LAUNCH, 3'd0, $random(seed), 32'd0, 32'd0);
    add_entry(OP_LAUNCH, 3'd0, $random(seed), 32'd0, 32'd3);
    add_entry(OP_LAUNCH, 3'd0, $random(seed), 32'd0, 32'd10);
    // back-pressure with W sent ahead of AW
    add_entry(OP_RD_BP, 3'd2, 32'd0, core_state.state1, 32'd0);
    r = $random(seed);
    add_entry(OP_WR_BP, 3'd0, r, 32'd0, 32'd0);
    add_entry(OP_RD, 3'd0, 32'd0, r, 32'd0);
    add_entry(OP_WDOG, 3'd0, 32'd0, 32'd0, 32'd0);
    add_entry(OP_BUTTON, 3'd0, 32'd0, 32'd0, 32'd0);

    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check(axil_rsp.arready, 1'b1, "arready after reset");
    check(axil_rsp.awready, 1'b1, "awready after reset");
    check(axil_rsp.wready, 1'b1, "wready after reset");
    check(axil_rsp.bvalid, 1'b0, "bvalid after reset");
    check(axil_rsp.rvalid, 1'b0, "rvalid after reset");
    check(cmd.valid, 1'b0, "cmd valid after reset");
    check(core_reset, 1'b0, "core reset after reset");

    for (int i = 0; i < tbl.size(); i++) begin
      case (tbl[i].op)
        OP_RD: begin
          read_reg(tbl[i].idx, 0, rd_word);
          check(rd_word, tbl[i].exp, $sformatf("read index %0d", tbl[i].idx));
        end
        OP_WR:     write_reg(tbl[i].idx, tbl[i].wdata, 1'b0, 0);
        OP_LAUNCH: launch_and_check(tbl[i].delay, tbl[i].wdata);
        OP_RD_BP: begin
          read_reg(tbl[i].idx, BP_CYCLES, rd_word);
          check(rd_word, tbl[i].exp, $sformatf("stalled read index %0d", tbl[i].idx));
        end
        OP_WR_BP:  write_reg(tbl[i].idx, tbl[i].wdata, 1'b1, BP_CYCLES);
        OP_WDOG:   watchdog_reset_test();
        default:   pulse_button();
      endcase
    end

    $display("%0d value errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== kernel_host_top.f ====
+incdir+.
kh_pkg.sv
axil_ctrl.sv
kernel_reg_bank.sv
cmd_launcher.sv
heartbeat_watchdog.sv
kernel_host_top.sv
tb_kernel_host.sv
